// ==== rob_commit.sv ====
`default_nettype none

module rob_commit import rob_pkg::*; (
  input  wire logic [CMT_BLK_W-1:0] i_head_id,
  input  wire rob_entry_t           i_entry [CMT_SIZE],
  input  wire logic [CMT_SIZE-1:0]  i_valid,
  input  wire logic [CMT_SIZE-1:0]  i_all_done,

  output      logic                 o_commit_valid,
  output      commit_t              o_commit,
  input  wire logic                 i_commit_ready,
  output      logic                 o_commit_fire
);

  rob_entry_t w_head;

  assign w_head = i_entry[i_head_id];

  // head is offered as soon as every valid slot has reported.
  assign o_commit_valid = i_valid[i_head_id] & i_all_done[i_head_id];
  assign o_commit_fire  = o_commit_valid & i_commit_ready;

  always_comb begin
    o_commit.cmt_id       = i_head_id;
    o_commit.pc_addr      = w_head.blk.pc_addr;
    o_commit.grp_id       = w_head.blk.grp_id;
    o_commit.old_rd_valid = w_head.blk.old_rd_valid & w_head.blk.grp_id;
    for (int d = 0; d < DISP_SIZE; d++) begin
      // unused slot carries a zero rnid.
      if (w_head.blk.grp_id[d]) begin
        o_commit.old_rd_rnid[d] = w_head.blk.old_rd_rnid[d];
      end else begin
        o_commit.old_rd_rnid[d] = '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rob_entry.sv ====
`default_nettype none

module rob_entry import rob_pkg::*; #(
  parameter logic [CMT_BLK_W-1:0] cmt_id = '0
) (
  input  wire logic       i_clk,
  input  wire logic       i_reset_n,

  input  wire logic       i_load,
  input  wire disp_blk_t  i_load_blk,
  input  wire logic       i_clear,

  input  wire done_rpt_t  i_done_rpt [CMT_BUS_SIZE],

  output      logic       o_valid,
  output      rob_entry_t o_entry,
  output      logic       o_block_all_done
);

  logic                 r_valid;
  logic [DISP_SIZE-1:0] r_done_grp_id;
  disp_blk_t            r_blk;
  logic [DISP_SIZE-1:0] w_done_hit;

  // per slot, any bus reporting this entry and this slot.
  always_comb begin
    w_done_hit = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      for (int c = 0; c < CMT_BUS_SIZE; c++) begin
        if (i_done_rpt[c].valid && (i_done_rpt[c].cmt_id == cmt_id) &&
            i_done_rpt[c].grp_id[d]) begin
          w_done_hit[d] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid       <= 1'b0;
      r_done_grp_id <= '0;
    end else begin
      if (i_load) begin
        r_valid       <= 1'b1;
        r_done_grp_id <= '0;  // fresh block, nothing done yet.
      end else begin
        if (i_clear) begin
          r_valid <= 1'b0;
        end
        if (r_valid) begin
          r_done_grp_id <= r_done_grp_id | w_done_hit;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_blk <= i_load_blk;
    end
  end

  assign o_valid             = r_valid;
  assign o_entry.blk         = r_blk;
  assign o_entry.done_grp_id = r_done_grp_id;

  // held entry stays all-done until commit clears it.
  assign o_block_all_done = r_valid & (r_blk.grp_id == r_done_grp_id);

endmodule

`default_nettype wire

// ==== rob_pkg.sv ====
`default_nettype none

package rob_pkg;

  localparam int DISP_SIZE    = 2;  // instruction slots per block.
  localparam int CMT_SIZE     = 8;  // rob entries.
  localparam int CMT_BLK_W    = 3;  // commit id width.
  localparam int CMT_CNT_W    = 4;  // occupancy count, 0 to CMT_SIZE.
  localparam int CMT_BUS_SIZE = 2;  // done report buses.
  localparam int RNID_W       = 6;
  localparam int VADDR_W      = 16;
  localparam int INST_W       = 32;

  // one block as handed over by dispatch.
  typedef struct packed {
    logic [DISP_SIZE-1:0]             grp_id;
    logic [VADDR_W-1:1]               pc_addr;  // bit 0 is always zero.
    logic [DISP_SIZE-1:0][INST_W-1:0] inst;
    logic [DISP_SIZE-1:0]             old_rd_valid;
    logic [DISP_SIZE-1:0][RNID_W-1:0] old_rd_rnid;
  } disp_blk_t;

  // completion report from an execution unit, grp_id is one-hot.
  typedef struct packed {
    logic                 valid;
    logic [CMT_BLK_W-1:0] cmt_id;
    logic [DISP_SIZE-1:0] grp_id;
  } done_rpt_t;

  // committed block, instruction words are not carried.
  typedef struct packed {
    logic [CMT_BLK_W-1:0]             cmt_id;
    logic [VADDR_W-1:1]               pc_addr;
    logic [DISP_SIZE-1:0]             grp_id;
    logic [DISP_SIZE-1:0]             old_rd_valid;
    logic [DISP_SIZE-1:0][RNID_W-1:0] old_rd_rnid;
  } commit_t;

  // stored entry state.
  typedef struct packed {
    disp_blk_t            blk;
    logic [DISP_SIZE-1:0] done_grp_id;
  } rob_entry_t;

endpackage

`default_nettype wire

// ==== rob_props.sv ====
`default_nettype none

module rob_props import rob_pkg::*; (
  input wire logic                 i_clk,
  input wire logic                 i_reset_n,
  input wire logic                 i_disp_ready,
  input wire logic [CMT_CNT_W-1:0] i_cnt,
  input wire done_rpt_t            i_done_rpt [CMT_BUS_SIZE],
  input wire logic                 i_commit_valid,
  input wire commit_t              i_commit,
  input wire logic                 i_commit_ready
);

  commit_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid && !i_commit_ready |=> i_commit_valid && $stable(i_commit))
    else $error("commit packet dropped or changed under back-pressure");

  full_not_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_cnt == CMT_CNT_W'(CMT_SIZE)) |-> !i_disp_ready)
    else $error("dispatch ready while all entries are occupied");

  for (genvar c = 0; c < CMT_BUS_SIZE; c++) begin : g_rpt
    rpt_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_done_rpt[c].valid |-> $onehot(i_done_rpt[c].grp_id))
      else $error("done report with a grp_id that is not one-hot");
  end

  reset_idle: assert property (@(posedge i_clk) !i_reset_n |-> !i_commit_valid)
    else $error("commit valid during reset");

endmodule

bind rob_top rob_props u_rob_props (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_disp_ready   (o_disp_ready),
  .i_cnt          (u_rob_ptr.r_cnt),
  .i_done_rpt     (i_done_rpt),
  .i_commit_valid (o_commit_valid),
  .i_commit       (o_commit),
  .i_commit_ready (i_commit_ready)
);

`default_nettype wire

// ==== rob_ptr.sv ====
`default_nettype none

module rob_ptr import rob_pkg::*; (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,

  input  wire logic                 i_disp_valid,
  output      logic                 o_disp_ready,
  output      logic [CMT_BLK_W-1:0] o_tail_id,
  output      logic [CMT_SIZE-1:0]  o_load,

  input  wire logic                 i_commit_fire,
  output      logic [CMT_BLK_W-1:0] o_head_id,
  output      logic [CMT_SIZE-1:0]  o_clear
);

  logic [CMT_BLK_W-1:0] r_head;
  logic [CMT_BLK_W-1:0] r_tail;
  logic [CMT_CNT_W-1:0] r_cnt;
  logic                 r_ready;
  logic                 w_disp_fire;
  logic [CMT_CNT_W-1:0] w_cnt_nxt;

  assign w_disp_fire = i_disp_valid & r_ready;

  // dispatch and commit together leave the count unchanged.
  always_comb begin
    w_cnt_nxt = r_cnt;
    if (w_disp_fire && !i_commit_fire) begin
      w_cnt_nxt = r_cnt + 1'b1;
    end else if (!w_disp_fire && i_commit_fire) begin
      w_cnt_nxt = r_cnt - 1'b1;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_cnt   <= '0;
      r_ready <= 1'b1;
    end else begin
      if (w_disp_fire) begin
        r_tail <= r_tail + 1'b1;  // wraps at CMT_SIZE.
      end
      if (i_commit_fire) begin
        r_head <= r_head + 1'b1;
      end
      r_cnt   <= w_cnt_nxt;
      r_ready <= (w_cnt_nxt < CMT_CNT_W'(CMT_SIZE));
    end
  end

  assign o_disp_ready = r_ready;
  assign o_tail_id    = r_tail;
  assign o_head_id    = r_head;

  // one-hot strobes to the entries.
  assign o_load  = w_disp_fire   ? (CMT_SIZE'(1) << r_tail) : '0;
  assign o_clear = i_commit_fire ? (CMT_SIZE'(1) << r_head) : '0;

endmodule

`default_nettype wire

// ==== rob_top.sv ====
`default_nettype none

module rob_top import rob_pkg::*; (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,

  // dispatch.
  input  wire logic                 i_disp_valid,
  input  wire disp_blk_t            i_disp_blk,
  output      logic                 o_disp_ready,
  output      logic [CMT_BLK_W-1:0] o_disp_cmt_id,

  // completion reports.
  input  wire done_rpt_t            i_done_rpt [CMT_BUS_SIZE],

  // commit.
  output      logic                 o_commit_valid,
  output      commit_t              o_commit,
  input  wire logic                 i_commit_ready
);

  logic [CMT_SIZE-1:0]  w_load;
  logic [CMT_SIZE-1:0]  w_clear;
  logic [CMT_BLK_W-1:0] w_head_id;
  logic                 w_commit_fire;
  logic [CMT_SIZE-1:0]  w_entry_valid;
  logic [CMT_SIZE-1:0]  w_all_done;
  rob_entry_t           w_entry [CMT_SIZE];

  rob_ptr u_rob_ptr (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .o_disp_ready  (o_disp_ready),
    .o_tail_id     (o_disp_cmt_id),
    .o_load        (w_load),
    .i_commit_fire (w_commit_fire),
    .o_head_id     (w_head_id),
    .o_clear       (w_clear)
  );

  for (genvar i = 0; i < CMT_SIZE; i++) begin : g_entry
    rob_entry #(
      .cmt_id (CMT_BLK_W'(i))
    ) u_rob_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_load           (w_load[i]),
      .i_load_blk       (i_disp_blk),
      .i_clear          (w_clear[i]),
      .i_done_rpt       (i_done_rpt),
      .o_valid          (w_entry_valid[i]),
      .o_entry          (w_entry[i]),
      .o_block_all_done (w_all_done[i])
    );
  end

  rob_commit u_rob_commit (
    .i_head_id      (w_head_id),
    .i_entry        (w_entry),
    .i_valid        (w_entry_valid),
    .i_all_done     (w_all_done),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .i_commit_ready (i_commit_ready),
    .o_commit_fire  (w_commit_fire)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
rob_pkg.sv
rob_entry.sv
rob_ptr.sv
rob_commit.sv
rob_top.sv
rob_props.sv
tb_rob.sv

// ==== tb_rob_model.svh ====
`ifndef TB_ROB_MODEL_SVH
`define TB_ROB_MODEL_SVH

  // blocks indexed by commit id, the queue keeps dispatch order.
  disp_blk_t            mdl_blk  [CMT_SIZE];
  logic [DISP_SIZE-1:0] mdl_rpt  [CMT_SIZE];  // slots with a report issued.
  logic [DISP_SIZE-1:0] mdl_done [CMT_SIZE];  // slots whose report passed an edge.
  logic [CMT_BLK_W-1:0] mdl_q [$];
  logic [CMT_BLK_W-1:0] mdl_tail;

  function automatic void push_block(input disp_blk_t b);
    mdl_blk[mdl_tail]  = b;
    mdl_rpt[mdl_tail]  = '0;
    mdl_done[mdl_tail] = '0;
    mdl_q.push_back(mdl_tail);
    mdl_tail = mdl_tail + 1'b1;  // wraps with the id width.
  endfunction

  function automatic void retire_head();
    void'(mdl_q.pop_front());
  endfunction

  function automatic void record_done(input done_rpt_t r);
    if (r.valid) begin
      mdl_done[r.cmt_id] = mdl_done[r.cmt_id] | r.grp_id;
    end
  endfunction

  function automatic logic head_all_done();
    logic ok;
    ok = 1'b0;
    if (mdl_q.size() != 0) begin
      ok = (mdl_done[mdl_q[0]] == mdl_blk[mdl_q[0]].grp_id);
    end
    return ok;
  endfunction

  // unused slots commit with no old register.
  function automatic commit_t expected_commit();
    commit_t              c;
    logic [CMT_BLK_W-1:0] id;
    id        = mdl_q[0];
    c.cmt_id  = id;
    c.pc_addr = mdl_blk[id].pc_addr;
    c.grp_id  = mdl_blk[id].grp_id;
    for (int d = 0; d < DISP_SIZE; d++) begin
      c.old_rd_valid[d] = mdl_blk[id].grp_id[d] & mdl_blk[id].old_rd_valid[d];
      c.old_rd_rnid[d]  = mdl_blk[id].grp_id[d] ? mdl_blk[id].old_rd_rnid[d] : '0;
    end
    return c;
  endfunction

`endif

// ==== tb_rob.sv ====
`default_nettype none

module tb_rob import rob_pkg::*; ();

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 i_disp_valid;
  disp_blk_t            i_disp_blk;
  logic                 o_disp_ready;
  logic [CMT_BLK_W-1:0] o_disp_cmt_id;
  done_rpt_t            i_done_rpt [CMT_BUS_SIZE];
  logic                 o_commit_valid;
  commit_t              o_commit;
  logic                 i_commit_ready;

  logic [31:0] lcg_state;
  int          n_err;
  int          n_chk;
  int          n_timeout;
  int          n_commit;
  int unsigned disp_pct;   // chances out of 10.
  int unsigned rpt_pct;
  int unsigned ready_pct;

  `include "tb_rob_model.svh"

  rob_top i_rob_top (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp_blk     (i_disp_blk),
    .o_disp_ready   (o_disp_ready),
    .o_disp_cmt_id  (o_disp_cmt_id),
    .i_done_rpt     (i_done_rpt),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .i_commit_ready (i_commit_ready)
  );

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = lcg_next();
    return (r >> 16) % n;
  endfunction

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    n_chk++;
    if (got !== exp) begin
      n_err++;
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic disp_blk_t random_block();
    disp_blk_t b;
    b.grp_id       = DISP_SIZE'(rand_below(3) + 1);  // 01, 10 or 11.
    b.pc_addr      = (VADDR_W-1)'(lcg_next() >> 8);
    b.old_rd_valid = DISP_SIZE'(lcg_next() >> 12);
    for (int d = 0; d < DISP_SIZE; d++) begin
      b.inst[d]        = lcg_next();
      b.old_rd_rnid[d] = RNID_W'(lcg_next() >> 10);
    end
    return b;
  endfunction

  // one unreported slot of a random outstanding block, or nothing.
  function automatic done_rpt_t pick_report();
    done_rpt_t            r;
    logic [CMT_BLK_W-1:0] id;
    logic [DISP_SIZE-1:0] free;
    int unsigned          s;
    r = '0;
    if (mdl_q.size() != 0) begin
      id   = mdl_q[rand_below(mdl_q.size())];
      free = mdl_blk[id].grp_id & ~mdl_rpt[id];
      s    = rand_below(DISP_SIZE);
      for (int k = 0; k < DISP_SIZE; k++) begin
        if (!r.valid && free[(s + k) % DISP_SIZE]) begin
          r.valid  = 1'b1;
          r.cmt_id = id;
          r.grp_id = DISP_SIZE'(1) << ((s + k) % DISP_SIZE);
        end
      end
      mdl_rpt[id] = mdl_rpt[id] | r.grp_id;
    end
    return r;
  endfunction

  // check mid-cycle, update the model after the edge, then drive.
  task automatic step();
    logic      disp_fire;
    logic      commit_fire;
    done_rpt_t rpt [CMT_BUS_SIZE];
    @(negedge i_clk);
    check_val(o_disp_ready, mdl_q.size() < CMT_SIZE, "dispatch ready");
    check_val(o_disp_cmt_id, mdl_tail, "dispatch commit id");
    check_val(o_commit_valid, head_all_done(), "commit valid");
    if (o_commit_valid && mdl_q.size() != 0) begin
      check_val(o_commit, expected_commit(), "commit packet");
    end
    disp_fire   = i_disp_valid & o_disp_ready;
    commit_fire = o_commit_valid & i_commit_ready;
    rpt         = i_done_rpt;
    @(posedge i_clk);
    #2;
    if (commit_fire && mdl_q.size() != 0) begin
      retire_head();
      n_commit++;
    end
    for (int c = 0; c < CMT_BUS_SIZE; c++) begin
      record_done(rpt[c]);
    end
    if (disp_fire) begin
      push_block(i_disp_blk);
    end
    if (!(i_disp_valid && !disp_fire)) begin  // a stalled block stays as it is.
      i_disp_valid = 1'b0;
      if (rand_below(10) < disp_pct) begin
        i_disp_valid = 1'b1;
        i_disp_blk   = random_block();
      end
    end
    for (int c = 0; c < CMT_BUS_SIZE; c++) begin
      i_done_rpt[c] = '0;
      if (rand_below(10) < rpt_pct) begin
        i_done_rpt[c] = pick_report();
      end
    end
    i_commit_ready = (rand_below(10) < ready_pct);
  endtask

  task automatic run_random(input int cycles);
    disp_pct  = 6;
    rpt_pct   = 5;
    ready_pct = 7;
    for (int n = 0; n < cycles; n++) begin
      step();
    end
  endtask

  // stall commit until the rob is full, then hold the stall a while.
  task automatic fill_and_hold();
    int cycles;
    disp_pct  = 10;
    rpt_pct   = 10;
    ready_pct = 0;
    cycles    = 0;
    while (o_disp_ready && cycles < 100) begin
      step();
      cycles++;
    end
    if (o_disp_ready) begin
      $display("timeout: dispatch ready never dropped while commit was stalled");
      n_timeout++;
    end
    for (int n = 0; n < 12; n++) begin
      step();
    end
    check_val(o_disp_ready, 1'b0, "dispatch ready while full and stalled");
  endtask

  task automatic drain();
    int cycles;
    disp_pct  = 0;
    rpt_pct   = 10;
    ready_pct = 10;
    cycles    = 0;
    while ((mdl_q.size() != 0 || i_disp_valid) && cycles < 200) begin
      step();
      cycles++;
    end
    if (mdl_q.size() != 0 || i_disp_valid) begin
      $display("timeout: outstanding blocks did not drain");
      n_timeout++;
    end
    step();  // one idle cycle with nothing offered.
  endtask

  initial begin
    i_clk          = 1'b0;
    i_reset_n      = 1'b0;
    i_disp_valid   = 1'b0;
    i_disp_blk     = '0;
    i_commit_ready = 1'b0;
    for (int c = 0; c < CMT_BUS_SIZE; c++) begin
      i_done_rpt[c] = '0;
    end
    lcg_state = 32'd21628;
    mdl_tail  = '0;
    n_err     = 0;
    n_chk     = 0;
    n_timeout = 0;
    n_commit  = 0;
    disp_pct  = 0;
    rpt_pct   = 0;
    ready_pct = 0;
    repeat (2) @(posedge i_clk);
    #2;
    i_reset_n = 1'b1;
    run_random(400);
    fill_and_hold();
    run_random(100);
    drain();
    $display("errors %0d, timeouts %0d, checks %0d, commits %0d",
             n_err, n_timeout, n_chk, n_commit);
    if (n_err == 0 && n_timeout == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
